/* src/bp_pkg.sv */
package bp_pkg;

    // ------------------------------------------------------------------
    // 2-bit saturating counter states
    // ------------------------------------------------------------------
    // Upper bit set means predict taken
    localparam logic [1:0] STRONG_NT = 2'd0;
    localparam logic [1:0] WEAK_NT   = 2'd1;
    localparam logic [1:0] WEAK_T    = 2'd2;
    localparam logic [1:0] STRONG_T  = 2'd3;

    // New entries start out strongly taken
    localparam logic [1:0] ALLOC_STATE = STRONG_T;

    // ------------------------------------------------------------------
    // Chooser counters
    // ------------------------------------------------------------------
    // Upper bit set selects the gshare table
    localparam logic [1:0] CHOOSER_RESET = 2'd2;
    localparam logic [1:0] CHOOSER_MAX   = 2'd3;
    localparam logic [1:0] CHOOSER_MIN   = 2'd0;

    // ------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------
    // Instruction offset bits below the index
    localparam int INDEX_OFFSET = 2;

endpackage

/* src/bp_counter_table.sv */
`timescale 1ns/100ps

module bp_counter_table #(
    parameter int XLEN   = 32,
    parameter int IDX_W  = 4,
    parameter int SLOTS  = 3,
    parameter bit HASHED = 1'b0
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [IDX_W-1:0]           ghr,
    input  logic [SLOTS-1:0][XLEN-1:0] rd_addr,
    input  logic [SLOTS-1:0]           alloc_en,
    input  logic [SLOTS-1:0][XLEN-1:0] alloc_addr,
    input  logic                       upd_en,
    input  logic [XLEN-1:0]            upd_pc,
    input  logic                       upd_taken,
    input  logic [XLEN-1:0]            upd_target,
    output logic [SLOTS-1:0]           rd_hit,
    output logic [SLOTS-1:0]           rd_taken,
    output logic [SLOTS-1:0][XLEN-1:0] rd_target,
    output logic                       upd_dir_taken
);

    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_LO  = bp_pkg::INDEX_OFFSET + IDX_W;
    localparam int TAG_W   = XLEN - TAG_LO;

    // ------------------------------------------------------------------
    // Table storage
    // ------------------------------------------------------------------
    logic [ENTRIES-1:0] valid_q;
    logic [1:0]         ctr_q    [ENTRIES];
    logic [TAG_W-1:0]   tag_q    [ENTRIES];
    logic [XLEN-1:0]    target_q [ENTRIES];

    // Per-port indices and hits
    logic [IDX_W-1:0] rd_idx    [SLOTS];
    logic [IDX_W-1:0] alloc_idx [SLOTS];
    logic [SLOTS-1:0] alloc_hit;
    logic [SLOTS-1:0] alloc_wr;
    logic [IDX_W-1:0] upd_idx;
    logic             upd_hit;
    logic             upd_wr;

    // Gshare flavour folds the global history into the index
    function automatic logic [IDX_W-1:0] entry_index(
        input logic [XLEN-1:0]  addr,
        input logic [IDX_W-1:0] hist
    );
        logic [IDX_W-1:0] base;
        base = addr[bp_pkg::INDEX_OFFSET +: IDX_W];
        return HASHED ? (base ^ hist) : base;
    endfunction

    function automatic logic [TAG_W-1:0] entry_tag(input logic [XLEN-1:0] addr);
        return addr[XLEN-1:TAG_LO];
    endfunction

    // One saturating step toward the resolved direction
    function automatic logic [1:0] ctr_step(input logic [1:0] ctr, input logic taken);
        logic [1:0] nxt;
        case (ctr)
            bp_pkg::STRONG_NT: nxt = taken ? bp_pkg::WEAK_NT  : bp_pkg::STRONG_NT;
            bp_pkg::WEAK_NT:   nxt = taken ? bp_pkg::WEAK_T   : bp_pkg::STRONG_NT;
            bp_pkg::WEAK_T:    nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_NT;
            default:           nxt = taken ? bp_pkg::STRONG_T : bp_pkg::WEAK_T;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------------
    // Fetch lookup
    // ------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            rd_idx[s]    = entry_index(rd_addr[s], ghr);
            rd_hit[s]    = valid_q[rd_idx[s]] && (tag_q[rd_idx[s]] == entry_tag(rd_addr[s]));
            rd_taken[s]  = rd_hit[s] && ctr_q[rd_idx[s]][1];
            // Target only leaves the table for a taken hit
            rd_target[s] = rd_taken[s] ? target_q[rd_idx[s]] : '0;
        end
    end

    // ------------------------------------------------------------------
    // Update and allocation decode
    // ------------------------------------------------------------------
    assign upd_idx       = entry_index(upd_pc, ghr);
    assign upd_hit       = valid_q[upd_idx] && (tag_q[upd_idx] == entry_tag(upd_pc));
    assign upd_wr        = upd_en && upd_hit;
    // Direction before training, used by the chooser
    assign upd_dir_taken = ctr_q[upd_idx][1];

    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            alloc_idx[s] = entry_index(alloc_addr[s], ghr);
            alloc_hit[s] = valid_q[alloc_idx[s]]
                        && (tag_q[alloc_idx[s]] == entry_tag(alloc_addr[s]));
            // Training of the same entry keeps it from being replaced
            alloc_wr[s]  = alloc_en[s] && !alloc_hit[s]
                        && !(upd_wr && (alloc_idx[s] == upd_idx));
        end
    end

    // ------------------------------------------------------------------
    // State write
    // ------------------------------------------------------------------
    // Slot 0 is written last so it wins a shared index
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= bp_pkg::STRONG_NT;
            end
        end else begin
            for (int s = SLOTS - 1; s >= 0; s--) begin
                if (alloc_wr[s]) begin
                    valid_q[alloc_idx[s]] <= 1'b1;
                    ctr_q[alloc_idx[s]]   <= bp_pkg::ALLOC_STATE;
                end
            end
            if (upd_wr) begin
                ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd_taken);
            end
        end
    end

    // Tag and target payload
    always_ff @(posedge clk) begin
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (alloc_wr[s]) begin
                tag_q[alloc_idx[s]]    <= entry_tag(alloc_addr[s]);
                target_q[alloc_idx[s]] <= '0;
            end
        end
        if (upd_wr) begin
            target_q[upd_idx] <= upd_target;
        end
    end

    // Strobes must be known once out of reset
    a_strobe_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown({alloc_en, upd_en})
    );

endmodule

/* src/bp_tournament_select.sv */
`timescale 1ns/100ps

module bp_tournament_select #(
    parameter int XLEN  = 32,
    parameter int IDX_W = 4,
    parameter int SLOTS = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [SLOTS-1:0]           fetch_en,
    input  logic [SLOTS-1:0][XLEN-1:0] fetch_addr,
    input  logic [SLOTS-1:0]           loc_hit,
    input  logic [SLOTS-1:0]           loc_taken,
    input  logic [SLOTS-1:0][XLEN-1:0] loc_target,
    input  logic [SLOTS-1:0]           gsh_hit,
    input  logic [SLOTS-1:0]           gsh_taken,
    input  logic [SLOTS-1:0][XLEN-1:0] gsh_target,
    input  logic                       upd_en,
    input  logic [XLEN-1:0]            upd_pc,
    input  logic                       upd_taken,
    input  logic                       loc_dir_taken,
    input  logic                       gsh_dir_taken,
    output logic [IDX_W-1:0]           ghr,
    output logic [SLOTS-1:0]           pred_valid,
    output logic [SLOTS-1:0]           pred_taken,
    output logic [SLOTS-1:0][XLEN-1:0] pred_target
);

    localparam int ENTRIES = 1 << IDX_W;

    logic [1:0]       chooser_q [ENTRIES];
    logic [IDX_W-1:0] ghr_q;

    logic [IDX_W-1:0] fetch_idx [SLOTS];
    logic [SLOTS-1:0] use_gsh;
    logic [IDX_W-1:0] upd_idx;
    logic             loc_ok;
    logic             gsh_ok;

    assign ghr = ghr_q;

    // ------------------------------------------------------------------
    // Per-slot choice between the two tables
    // ------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            fetch_idx[s] = fetch_addr[s][bp_pkg::INDEX_OFFSET +: IDX_W];
            use_gsh[s]   = chooser_q[fetch_idx[s]][1];
            if (!fetch_en[s]) begin
                pred_valid[s]  = 1'b0;
                pred_taken[s]  = 1'b0;
                pred_target[s] = '0;
            end else if (use_gsh[s]) begin
                pred_valid[s]  = gsh_hit[s];
                pred_taken[s]  = gsh_taken[s];
                pred_target[s] = gsh_target[s];
            end else begin
                pred_valid[s]  = loc_hit[s];
                pred_taken[s]  = loc_taken[s];
                pred_target[s] = loc_target[s];
            end
        end
    end

    // ------------------------------------------------------------------
    // Chooser training
    // ------------------------------------------------------------------
    // Chooser shares the local index
    assign upd_idx = upd_pc[bp_pkg::INDEX_OFFSET +: IDX_W];
    assign loc_ok  = (loc_dir_taken == upd_taken);
    assign gsh_ok  = (gsh_dir_taken == upd_taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                chooser_q[i] <= bp_pkg::CHOOSER_RESET;
            end
        end else if (upd_en) begin
            // Move only when the tables disagree on correctness
            if (gsh_ok && !loc_ok && (chooser_q[upd_idx] != bp_pkg::CHOOSER_MAX)) begin
                chooser_q[upd_idx] <= chooser_q[upd_idx] + 2'd1;
            end else if (loc_ok && !gsh_ok
                         && (chooser_q[upd_idx] != bp_pkg::CHOOSER_MIN)) begin
                chooser_q[upd_idx] <= chooser_q[upd_idx] - 2'd1;
            end
        end
    end

    // Global history, newest outcome in bit 0
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr_q <= '0;
        end else if (upd_en) begin
            ghr_q <= {ghr_q[IDX_W-2:0], upd_taken};
        end
    end

    // Tables only return a target with a taken hit
    for (genvar s = 0; s < SLOTS; s++) begin : g_chk
        a_target_when_nt: assert property (
            @(posedge clk) disable iff (rst) !pred_taken[s] |-> (pred_target[s] == '0)
        );
    end

endmodule

/* src/branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor #(
    parameter int XLEN  = 32,
    parameter int IDX_W = 4,
    parameter int SLOTS = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [SLOTS-1:0]           fetch_en,
    input  logic [SLOTS-1:0][XLEN-1:0] fetch_addr,
    input  logic [SLOTS-1:0]           disp_en,
    input  logic [SLOTS-1:0][XLEN-1:0] disp_addr,
    input  logic                       upd_en,
    input  logic [XLEN-1:0]            upd_pc,
    input  logic                       upd_taken,
    input  logic [XLEN-1:0]            upd_target,
    output logic [SLOTS-1:0]           pred_valid,
    output logic [SLOTS-1:0]           pred_taken,
    output logic [SLOTS-1:0][XLEN-1:0] pred_target
);

    logic [IDX_W-1:0]           ghr;
    logic [SLOTS-1:0]           loc_hit;
    logic [SLOTS-1:0]           loc_taken;
    logic [SLOTS-1:0][XLEN-1:0] loc_target;
    logic                       loc_dir_taken;
    logic [SLOTS-1:0]           gsh_hit;
    logic [SLOTS-1:0]           gsh_taken;
    logic [SLOTS-1:0][XLEN-1:0] gsh_target;
    logic                       gsh_dir_taken;

    // ------------------------------------------------------------------
    // Local and gshare tables
    // ------------------------------------------------------------------
    bp_counter_table #(
        .XLEN(XLEN), .IDX_W(IDX_W), .SLOTS(SLOTS), .HASHED(1'b0)
    ) u_local_table (
        .clk(clk), .rst(rst), .ghr(ghr),
        .rd_addr(fetch_addr),
        .alloc_en(disp_en), .alloc_addr(disp_addr),
        .upd_en(upd_en), .upd_pc(upd_pc),
        .upd_taken(upd_taken), .upd_target(upd_target),
        .rd_hit(loc_hit), .rd_taken(loc_taken), .rd_target(loc_target),
        .upd_dir_taken(loc_dir_taken)
    );

    bp_counter_table #(
        .XLEN(XLEN), .IDX_W(IDX_W), .SLOTS(SLOTS), .HASHED(1'b1)
    ) u_gshare_table (
        .clk(clk), .rst(rst), .ghr(ghr),
        .rd_addr(fetch_addr),
        .alloc_en(disp_en), .alloc_addr(disp_addr),
        .upd_en(upd_en), .upd_pc(upd_pc),
        .upd_taken(upd_taken), .upd_target(upd_target),
        .rd_hit(gsh_hit), .rd_taken(gsh_taken), .rd_target(gsh_target),
        .upd_dir_taken(gsh_dir_taken)
    );

    // ------------------------------------------------------------------
    // Chooser and global history
    // ------------------------------------------------------------------
    bp_tournament_select #(
        .XLEN(XLEN), .IDX_W(IDX_W), .SLOTS(SLOTS)
    ) u_select (
        .clk(clk), .rst(rst),
        .fetch_en(fetch_en), .fetch_addr(fetch_addr),
        .loc_hit(loc_hit), .loc_taken(loc_taken), .loc_target(loc_target),
        .gsh_hit(gsh_hit), .gsh_taken(gsh_taken), .gsh_target(gsh_target),
        .upd_en(upd_en), .upd_pc(upd_pc), .upd_taken(upd_taken),
        .loc_dir_taken(loc_dir_taken), .gsh_dir_taken(gsh_dir_taken),
        .ghr(ghr),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_target(pred_target)
    );

endmodule

/* verif/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// ----------------------------------------------------------------------
// Reference state, table 0 is local and table 1 is gshare
// ----------------------------------------------------------------------
logic             m_valid   [2][ENTRIES];
logic [1:0]       m_ctr     [2][ENTRIES];
logic [TAG_W-1:0] m_tag     [2][ENTRIES];
logic [XLEN-1:0]  m_target  [2][ENTRIES];
logic [1:0]       m_chooser [ENTRIES];
logic [IDX_W-1:0] m_ghr;

function automatic logic [IDX_W-1:0] local_index(input logic [XLEN-1:0] addr);
    return addr[bp_pkg::INDEX_OFFSET +: IDX_W];
endfunction

function automatic logic [IDX_W-1:0] table_index(input int t, input logic [XLEN-1:0] addr);
    return (t == 1) ? (local_index(addr) ^ m_ghr) : local_index(addr);
endfunction

function automatic logic table_hit(input int t, input logic [XLEN-1:0] addr);
    logic [IDX_W-1:0] i;
    i = table_index(t, addr);
    return m_valid[t][i] && (m_tag[t][i] == addr[XLEN-1:TAG_LO]);
endfunction

// Saturating 2-bit counter
function automatic logic [1:0] train(input logic [1:0] ctr, input logic taken);
    if (taken) begin
        return (ctr == bp_pkg::STRONG_T) ? ctr : ctr + 2'd1;
    end
    return (ctr == bp_pkg::STRONG_NT) ? ctr : ctr - 2'd1;
endfunction

// Expected {valid, taken, target} of one fetch slot
function automatic logic [XLEN+1:0] expected_pred(input logic en, input logic [XLEN-1:0] addr);
    int               t;
    logic [IDX_W-1:0] i;
    logic             hit;
    logic             tk;
    if (!en) begin
        return '0;
    end
    t   = m_chooser[local_index(addr)][1] ? 1 : 0;
    i   = table_index(t, addr);
    hit = table_hit(t, addr);
    tk  = hit && m_ctr[t][i][1];
    return {hit, tk, tk ? m_target[t][i] : {XLEN{1'b0}}};
endfunction

function automatic void model_reset();
    for (int t = 0; t < 2; t++) begin
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[t][i]  = 1'b0;
            m_ctr[t][i]    = bp_pkg::STRONG_NT;
            m_tag[t][i]    = '0;
            m_target[t][i] = '0;
        end
    end
    for (int i = 0; i < ENTRIES; i++) begin
        m_chooser[i] = bp_pkg::CHOOSER_RESET;
    end
    m_ghr = '0;
endfunction

// One rising edge worth of allocation, training and history shift
function automatic void model_step(
    input logic [SLOTS-1:0]           d_en,
    input logic [SLOTS-1:0][XLEN-1:0] d_addr,
    input logic                       u_en,
    input logic [XLEN-1:0]            u_pc,
    input logic                       u_tk,
    input logic [XLEN-1:0]            u_tgt
);
    logic [IDX_W-1:0] ui   [2];
    logic             uhit [2];
    logic             dir  [2];
    logic [IDX_W-1:0] ai   [2][SLOTS];
    logic             aw   [2][SLOTS];
    logic [IDX_W-1:0] ci;
    // Decide everything from the state before the edge
    for (int t = 0; t < 2; t++) begin
        ui[t]   = table_index(t, u_pc);
        uhit[t] = u_en && table_hit(t, u_pc);
        dir[t]  = m_ctr[t][ui[t]][1];
        for (int s = 0; s < SLOTS; s++) begin
            ai[t][s] = table_index(t, d_addr[s]);
            aw[t][s] = d_en[s] && !table_hit(t, d_addr[s])
                    && !(uhit[t] && (ai[t][s] == ui[t]));
        end
    end
    // Slot 0 lands last and keeps a shared entry
    for (int t = 0; t < 2; t++) begin
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (aw[t][s]) begin
                m_valid[t][ai[t][s]]  = 1'b1;
                m_ctr[t][ai[t][s]]    = bp_pkg::ALLOC_STATE;
                m_tag[t][ai[t][s]]    = d_addr[s][XLEN-1:TAG_LO];
                m_target[t][ai[t][s]] = '0;
            end
        end
        if (uhit[t]) begin
            m_ctr[t][ui[t]]    = train(m_ctr[t][ui[t]], u_tk);
            m_target[t][ui[t]] = u_tgt;
        end
    end
    if (u_en) begin
        ci = local_index(u_pc);
        if (dir[1] == u_tk && dir[0] != u_tk && m_chooser[ci] != bp_pkg::CHOOSER_MAX) begin
            m_chooser[ci] = m_chooser[ci] + 2'd1;
        end else if (dir[0] == u_tk && dir[1] != u_tk
                     && m_chooser[ci] != bp_pkg::CHOOSER_MIN) begin
            m_chooser[ci] = m_chooser[ci] - 2'd1;
        end
        m_ghr = {m_ghr[IDX_W-2:0], u_tk};
    end
endfunction

`endif

/* verif/tb_branch_predictor.sv */
`timescale 1ns/100ps

module tb_branch_predictor;

    localparam int XLEN       = 32;
    localparam int IDX_W      = 4;
    localparam int SLOTS      = 3;
    localparam int ENTRIES    = 1 << IDX_W;
    localparam int TAG_LO     = bp_pkg::INDEX_OFFSET + IDX_W;
    localparam int TAG_W      = XLEN - TAG_LO;
    localparam int MAX_CYCLES = 2000;

    // Three branches on distinct indices, one alias of A1 and a history flush PC
    localparam logic [XLEN-1:0] ADDR_A0   = 32'h0000_1000;
    localparam logic [XLEN-1:0] ADDR_A1   = 32'h0000_2014;
    localparam logic [XLEN-1:0] ADDR_A2   = 32'h0000_3028;
    localparam logic [XLEN-1:0] ADDR_B    = 32'h0000_5014;
    localparam logic [XLEN-1:0] FLUSH_PC  = 32'h0000_f03c;
    localparam logic [XLEN-1:0] TARGET_A0 = 32'h0000_8000;

    logic                       clk;
    logic                       rst;
    logic [SLOTS-1:0]           fetch_en;
    logic [SLOTS-1:0][XLEN-1:0] fetch_addr;
    logic [SLOTS-1:0]           disp_en;
    logic [SLOTS-1:0][XLEN-1:0] disp_addr;
    logic                       upd_en;
    logic [XLEN-1:0]            upd_pc;
    logic                       upd_taken;
    logic [XLEN-1:0]            upd_target;
    logic [SLOTS-1:0]           pred_valid;
    logic [SLOTS-1:0]           pred_taken;
    logic [SLOTS-1:0][XLEN-1:0] pred_target;

    int          checks         = 0;
    int          check_errors   = 0;
    int          timeouts       = 0;
    string       test_name      = "reset";
    logic [31:0] lcg_state      = 32'hfdd2_e1c2;
    logic        chooser_at_max = 1'b0;
    logic        chooser_at_min = 1'b0;

    `include "bp_ref_model.svh"

    branch_predictor #(
        .XLEN(XLEN), .IDX_W(IDX_W), .SLOTS(SLOTS)
    ) u_branch_predictor (
        .clk(clk), .rst(rst),
        .fetch_en(fetch_en), .fetch_addr(fetch_addr),
        .disp_en(disp_en), .disp_addr(disp_addr),
        .upd_en(upd_en), .upd_pc(upd_pc),
        .upd_taken(upd_taken), .upd_target(upd_target),
        .pred_valid(pred_valid), .pred_taken(pred_taken), .pred_target(pred_target)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Model follows the DUT on every rising edge
    always @(posedge clk) begin
        if (rst) begin
            model_reset();
        end else begin
            model_step(disp_en, disp_addr, upd_en, upd_pc, upd_taken, upd_target);
        end
    end

    // ----------------------------------------------------------------------
    // Every slot compared against the model mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk) begin : compare
        logic [XLEN+1:0] want;
        if (!rst) begin
            for (int s = 0; s < SLOTS; s++) begin
                want = expected_pred(fetch_en[s], fetch_addr[s]);
                checks++;
                assert ({pred_valid[s], pred_taken[s], pred_target[s]} == want) else begin
                    check_errors++;
                    $display("Error %s slot %0d: expected %h actual %h", test_name, s, want,
                             {pred_valid[s], pred_taken[s], pred_target[s]});
                end
            end
        end
    end

    // Chooser saturation reached anywhere in the table
    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (m_chooser[i] == bp_pkg::CHOOSER_MAX) begin
                    chooser_at_max = 1'b1;
                end
                if (m_chooser[i] == bp_pkg::CHOOSER_MIN) begin
                    chooser_at_min = 1'b1;
                end
            end
        end
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("tests failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Small tag space so random branches alias often
    function automatic logic [XLEN-1:0] pick_addr(input logic [31:0] r);
        logic [XLEN-1:0] a;
        a = '0;
        a[bp_pkg::INDEX_OFFSET +: IDX_W] = r[IDX_W-1:0];
        a[TAG_LO +: 2] = r[17:16];
        return a;
    endfunction

    task automatic idle_inputs();
        fetch_en   = '0;
        fetch_addr = '0;
        disp_en    = '0;
        disp_addr  = '0;
        upd_en     = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_pred(input int s, input logic v, input logic t,
                              input logic [XLEN-1:0] tgt);
        checks++;
        assert (pred_valid[s] == v && pred_taken[s] == t && pred_target[s] == tgt) else begin
            check_errors++;
            $display("Error %s slot %0d: expected %b/%b/%h actual %b/%b/%h", test_name, s,
                     v, t, tgt, pred_valid[s], pred_taken[s], pred_target[s]);
        end
    endtask

    task automatic wait_for_valid(input logic [SLOTS-1:0] mask, input int limit);
        int n;
        n = 0;
        #1;
        while (((pred_valid & mask) != mask) && (n < limit)) begin
            next_cycle();
            n++;
        end
        if ((pred_valid & mask) != mask) begin
            timeouts++;
            $display("Timeout in %s: pred_valid never reached %b", test_name, mask);
        end
    endtask

    task automatic update_branch(input logic [XLEN-1:0] pc, input logic taken,
                                 input logic [XLEN-1:0] target);
        upd_en     = 1'b1;
        upd_pc     = pc;
        upd_taken  = taken;
        upd_target = target;
        next_cycle();
        upd_en     = 1'b0;
    endtask

    // Not-taken updates on an unused branch bring the history back to 0
    task automatic flush_history();
        repeat (IDX_W) update_branch(FLUSH_PC, 1'b0, '0);
    endtask

    task automatic random_traffic(input int cycles);
        logic [31:0] r;
        for (int c = 0; c < cycles; c++) begin
            r          = lcg_next();
            fetch_en   = r[2:0];
            disp_en    = r[5:3] & r[8:6];
            upd_en     = r[9] | r[10];
            upd_taken  = r[11];
            upd_pc     = pick_addr(lcg_next());
            upd_target = lcg_next();
            for (int s = 0; s < SLOTS; s++) begin
                fetch_addr[s] = pick_addr(lcg_next());
                disp_addr[s]  = pick_addr(lcg_next());
            end
            // Collide dispatch and fetch with the update now and then
            if (r[13:12] == 2'b00) begin
                disp_addr[r[14]] = upd_pc;
                // Another tag on the same index contends with the trained entry
                disp_addr[r[14]][TAG_LO] = upd_pc[TAG_LO] ^ r[16];
            end
            if (r[15]) begin
                fetch_addr[0] = upd_pc;
            end
            next_cycle();
        end
    endtask

    task automatic report();
        checks++;
        assert (chooser_at_max && chooser_at_min) else begin
            check_errors++;
            $display("Chooser never reached both saturation limits during the run");
        end
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        idle_inputs();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name  = "reset_fetch";
        fetch_en   = '1;
        fetch_addr = {ADDR_A2, ADDR_A1, ADDR_A0};
        #10;
        for (int s = 0; s < SLOTS; s++) check_pred(s, 1'b0, 1'b0, '0);
        next_cycle();

        // Three allocations in one cycle, then all three start strongly taken
        test_name = "alloc_three";
        idle_inputs();
        disp_en   = '1;
        disp_addr = {ADDR_A2, ADDR_A1, ADDR_A0};
        next_cycle();
        idle_inputs();
        fetch_en   = '1;
        fetch_addr = {ADDR_A2, ADDR_A1, ADDR_A0};
        wait_for_valid('1, 4);
        for (int s = 0; s < SLOTS; s++) check_pred(s, 1'b1, 1'b1, '0);
        next_cycle();

        test_name = "train_down";
        idle_inputs();
        repeat (3) update_branch(ADDR_A0, 1'b0, '0);
        fetch_en   = '1;
        fetch_addr = {ADDR_A2, ADDR_A1, ADDR_A0};
        #10;
        check_pred(0, 1'b1, 1'b0, '0);
        next_cycle();

        // History is cleared between steps so gshare keeps indexing entry 0
        test_name = "train_up";
        idle_inputs();
        repeat (3) begin
            update_branch(ADDR_A0, 1'b1, TARGET_A0);
            flush_history();
        end
        fetch_en   = '1;
        fetch_addr = {ADDR_A2, ADDR_A1, ADDR_A0};
        #10;
        check_pred(0, 1'b1, 1'b1, TARGET_A0);
        next_cycle();

        test_name  = "tag_conflict";
        idle_inputs();
        fetch_en   = 3'b010;
        fetch_addr = {ADDR_A2, ADDR_B, ADDR_A0};
        #10;
        check_pred(1, 1'b0, 1'b0, '0);
        next_cycle();
        idle_inputs();
        disp_en   = 3'b001;
        disp_addr = {ADDR_A2, ADDR_A1, ADDR_B};
        next_cycle();
        idle_inputs();
        fetch_en   = 3'b011;
        fetch_addr = {ADDR_A2, ADDR_A1, ADDR_B};
        #10;
        check_pred(0, 1'b1, 1'b1, '0);
        check_pred(1, 1'b0, 1'b0, '0);
        next_cycle();

        test_name = "random_mix";
        random_traffic(600);
        idle_inputs();
        next_cycle();
        report();
        $finish;
    end

endmodule

/* list.f */
+incdir+verif
src/bp_pkg.sv
src/bp_counter_table.sv
src/bp_tournament_select.sv
src/branch_predictor.sv
verif/tb_branch_predictor.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_branch_predictor -f list.f -o sim_branch_predictor
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

sim_out=$(./obj_dir/sim_branch_predictor)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
